/* hdl/dma_pkg.sv */
package dma_pkg;

    // Memory word and byte address geometry
    localparam int DATA_W    = 128;
    localparam int STRB_W    = DATA_W / 8;
    localparam int ADDR_W    = 32;
    localparam int WORD_LSB  = 4;
    localparam int MEM_AW    = 10;

    // Burst format, length counts beats minus one
    localparam int LEN_W     = 8;
    localparam int MAX_BURST = 32;

    // Requesters on the shared RAM, writer sits on the last port
    localparam int NUM_RD    = 3;
    localparam int NUM_PORTS = NUM_RD + 1;
    localparam int PORT_W    = $clog2(NUM_PORTS);

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_ISSUE,
        CH_WAIT,
        CH_RESP
    } chan_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } burst_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } rd_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } wr_beat_t;

    typedef struct packed {
        mem_op_e           op;
        logic [MEM_AW-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } mem_req_t;

endpackage

/* hdl/word_ram.sv */
`timescale 1ns/1ps

module word_ram
    import dma_pkg::*;
(
    input  logic              clk,
    input  logic              en,
    input  mem_req_t          req,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [1 << MEM_AW];

    // Byte lanes follow the strobes
    always_ff @(posedge clk) begin
        if (en && req.op == MEM_WRITE) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req.strb[b]) begin
                    mem[req.addr][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, data one cycle after the enable
    always_ff @(posedge clk) begin
        if (en && req.op == MEM_READ) begin
            rdata <= mem[req.addr];
        end
    end

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
    import dma_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_req_t [NUM_PORTS-1:0] req,
    input  logic [NUM_PORTS-1:0]    req_valid,
    input  logic [DATA_W-1:0]       ram_rdata,
    output logic [NUM_PORTS-1:0]    grant,
    output logic                    ram_en,
    output mem_req_t                ram_req,
    output logic [DATA_W-1:0]       rd_data,
    output logic [NUM_RD-1:0]       rd_data_valid
);

    logic [PORT_W-1:0] last_q;
    logic [PORT_W-1:0] win;
    logic [PORT_W-1:0] idx;
    logic              found;
    logic [NUM_RD-1:0] rd_pend_q;

    // Search starts just past the last winner
    always_comb begin
        win   = last_q;
        idx   = '0;
        found = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = PORT_W'((int'(last_q) + k) % NUM_PORTS);
            if (!found && req_valid[idx]) begin
                win   = idx;
                found = 1'b1;
            end
        end
        grant      = '0;
        grant[win] = found;
    end

    assign ram_en  = found;
    assign ram_req = req[win];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q    <= PORT_W'(NUM_PORTS - 1);
            rd_pend_q <= '0;
        end else begin
            if (found) begin
                last_q <= win;
            end
            // Remember which reader owns the word coming out next cycle
            for (int i = 0; i < NUM_RD; i++) begin
                rd_pend_q[i] <= grant[i] && (req[i].op == MEM_READ);
            end
        end
    end

    assign rd_data       = ram_rdata;
    assign rd_data_valid = rd_pend_q;

endmodule

/* hdl/burst_reader.sv */
`timescale 1ns/1ps

module burst_reader
    import dma_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  burst_req_t        req,
    input  logic              req_valid,
    output logic              req_ready,
    output rd_beat_t          beat,
    output logic              beat_valid,
    input  logic              beat_ready,
    output mem_req_t          mem_req,
    output logic              mem_req_valid,
    input  logic              grant,
    input  logic [DATA_W-1:0] rd_data,
    input  logic              rd_data_valid
);

    chan_state_e       state_q;
    logic [MEM_AW-1:0] addr_q;
    logic [LEN_W-1:0]  cnt_q;
    logic [LEN_W-1:0]  len_clip;
    logic [DATA_W-1:0] data_q;

    // Bursts longer than MAX_BURST are cut short
    assign len_clip = (req.len > LEN_W'(MAX_BURST - 1)) ? LEN_W'(MAX_BURST - 1) : req.len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CH_IDLE;
            addr_q  <= '0;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                CH_IDLE: begin
                    if (req_valid) begin
                        addr_q  <= req.addr[WORD_LSB +: MEM_AW];
                        cnt_q   <= len_clip;
                        state_q <= CH_ISSUE;
                    end
                end
                CH_ISSUE: begin
                    if (grant) begin
                        state_q <= CH_WAIT;
                    end
                end
                CH_WAIT: begin
                    if (rd_data_valid) begin
                        state_q <= CH_RESP;
                    end
                end
                CH_RESP: begin
                    if (beat_ready) begin
                        if (cnt_q == '0) begin
                            state_q <= CH_IDLE;
                        end else begin
                            cnt_q   <= cnt_q - 1'b1;
                            addr_q  <= addr_q + 1'b1;
                            state_q <= CH_ISSUE;
                        end
                    end
                end
                default: state_q <= CH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CH_WAIT && rd_data_valid) begin
            data_q <= rd_data;
        end
    end

    assign req_ready     = (state_q == CH_IDLE);
    assign beat_valid    = (state_q == CH_RESP);
    assign beat.data     = data_q;
    assign beat.last     = (cnt_q == '0);
    assign mem_req_valid = (state_q == CH_ISSUE);
    assign mem_req.op    = MEM_READ;
    assign mem_req.addr  = addr_q;
    assign mem_req.data  = '0;
    assign mem_req.strb  = '0;

endmodule

/* hdl/burst_writer.sv */
`timescale 1ns/1ps

module burst_writer
    import dma_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  burst_req_t req,
    input  logic       req_valid,
    output logic       req_ready,
    input  wr_beat_t   beat,
    input  logic       beat_valid,
    output logic       beat_ready,
    output logic       resp_valid,
    input  logic       resp_ready,
    output mem_req_t   mem_req,
    output logic       mem_req_valid,
    input  logic       grant
);

    chan_state_e       state_q;
    logic [MEM_AW-1:0] addr_q;
    wr_beat_t          hold_q;

    // CH_WAIT waits for a beat, CH_ISSUE waits for the grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CH_IDLE;
            addr_q  <= '0;
        end else begin
            case (state_q)
                CH_IDLE: begin
                    if (req_valid) begin
                        addr_q  <= req.addr[WORD_LSB +: MEM_AW];
                        state_q <= CH_WAIT;
                    end
                end
                CH_WAIT: begin
                    if (beat_valid) begin
                        state_q <= CH_ISSUE;
                    end
                end
                CH_ISSUE: begin
                    if (grant) begin
                        addr_q  <= addr_q + 1'b1;
                        // End of burst is set by the last flag alone
                        state_q <= hold_q.last ? CH_RESP : CH_WAIT;
                    end
                end
                CH_RESP: begin
                    if (resp_ready) begin
                        state_q <= CH_IDLE;
                    end
                end
                default: state_q <= CH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CH_WAIT && beat_valid) begin
            hold_q <= beat;
        end
    end

    assign req_ready     = (state_q == CH_IDLE);
    assign beat_ready    = (state_q == CH_WAIT);
    assign resp_valid    = (state_q == CH_RESP);
    assign mem_req_valid = (state_q == CH_ISSUE);
    assign mem_req.op    = MEM_WRITE;
    assign mem_req.addr  = addr_q;
    assign mem_req.data  = hold_q.data;
    assign mem_req.strb  = hold_q.strb;

endmodule

/* hdl/burst_ram_top.sv */
`timescale 1ns/1ps

module burst_ram_top
    import dma_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  burst_req_t [NUM_RD-1:0]   rd_req,
    input  logic [NUM_RD-1:0]         rd_req_valid,
    output logic [NUM_RD-1:0]         rd_req_ready,
    output rd_beat_t [NUM_RD-1:0]     rd_beat,
    output logic [NUM_RD-1:0]         rd_beat_valid,
    input  logic [NUM_RD-1:0]         rd_beat_ready,
    input  burst_req_t                wr_req,
    input  logic                      wr_req_valid,
    output logic                      wr_req_ready,
    input  wr_beat_t                  wr_beat,
    input  logic                      wr_beat_valid,
    output logic                      wr_beat_ready,
    output logic                      wr_resp_valid,
    input  logic                      wr_resp_ready
);

    mem_req_t [NUM_PORTS-1:0] ch_req;
    logic [NUM_PORTS-1:0]     ch_req_valid;
    logic [NUM_PORTS-1:0]     grant;
    logic                     ram_en;
    mem_req_t                 ram_req;
    logic [DATA_W-1:0]        ram_rdata;
    logic [DATA_W-1:0]        rd_data;
    logic [NUM_RD-1:0]        rd_data_valid;

    burst_reader u_rd0 (
        .clk, .rst_n,
        .req (rd_req[0]), .req_valid (rd_req_valid[0]), .req_ready (rd_req_ready[0]),
        .beat (rd_beat[0]), .beat_valid (rd_beat_valid[0]), .beat_ready (rd_beat_ready[0]),
        .mem_req (ch_req[0]), .mem_req_valid (ch_req_valid[0]), .grant (grant[0]),
        .rd_data, .rd_data_valid (rd_data_valid[0])
    );

    burst_reader u_rd1 (
        .clk, .rst_n,
        .req (rd_req[1]), .req_valid (rd_req_valid[1]), .req_ready (rd_req_ready[1]),
        .beat (rd_beat[1]), .beat_valid (rd_beat_valid[1]), .beat_ready (rd_beat_ready[1]),
        .mem_req (ch_req[1]), .mem_req_valid (ch_req_valid[1]), .grant (grant[1]),
        .rd_data, .rd_data_valid (rd_data_valid[1])
    );

    burst_reader u_rd2 (
        .clk, .rst_n,
        .req (rd_req[2]), .req_valid (rd_req_valid[2]), .req_ready (rd_req_ready[2]),
        .beat (rd_beat[2]), .beat_valid (rd_beat_valid[2]), .beat_ready (rd_beat_ready[2]),
        .mem_req (ch_req[2]), .mem_req_valid (ch_req_valid[2]), .grant (grant[2]),
        .rd_data, .rd_data_valid (rd_data_valid[2])
    );

    // Writer takes the last arbiter port
    burst_writer u_wr (
        .clk, .rst_n,
        .req (wr_req), .req_valid (wr_req_valid), .req_ready (wr_req_ready),
        .beat (wr_beat), .beat_valid (wr_beat_valid), .beat_ready (wr_beat_ready),
        .resp_valid (wr_resp_valid), .resp_ready (wr_resp_ready),
        .mem_req (ch_req[NUM_RD]), .mem_req_valid (ch_req_valid[NUM_RD]),
        .grant (grant[NUM_RD])
    );

    mem_arbiter u_arb (
        .clk, .rst_n,
        .req (ch_req), .req_valid (ch_req_valid), .ram_rdata,
        .grant, .ram_en, .ram_req, .rd_data, .rd_data_valid
    );

    word_ram u_ram (
        .clk,
        .en (ram_en),
        .req (ram_req),
        .rdata (ram_rdata)
    );

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

/* verif/burst_ram_tb.sv */
`timescale 1ns/1ps

module burst_ram_tb
    import dma_pkg::*;
();

    // About ten times the cycles the six tests need
    localparam int CYCLE_LIMIT = 4000;

    logic                    clk;
    logic                    rst_n = 1'b1;
    burst_req_t [NUM_RD-1:0] rd_req = '0;
    logic [NUM_RD-1:0]       rd_req_valid = '0;
    logic [NUM_RD-1:0]       rd_req_ready;
    rd_beat_t [NUM_RD-1:0]   rd_beat;
    logic [NUM_RD-1:0]       rd_beat_valid;
    logic [NUM_RD-1:0]       rd_beat_ready = '1;
    burst_req_t              wr_req = '0;
    logic                    wr_req_valid = 1'b0;
    logic                    wr_req_ready;
    wr_beat_t                wr_beat = '0;
    logic                    wr_beat_valid = 1'b0;
    logic                    wr_beat_ready;
    logic                    wr_resp_valid;
    logic                    wr_resp_ready = 1'b0;

    logic [31:0]       lfsr_q = 32'h71f2_7769;
    logic [DATA_W-1:0] ref_mem [1 << MEM_AW];
    logic [DATA_W-1:0] exp_data [NUM_RD][256];
    logic              exp_last [NUM_RD][256];
    int                exp_n [NUM_RD];
    int                got_n [NUM_RD];
    logic              resp_pending = 1'b0;
    logic              rand_ready = 1'b0;
    int                errors = 0;
    int                err_mark = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                cycles = 0;

    tb_clock u_clk (.clk);

    burst_ram_top u_burst_ram_top (.*);

    // Taps 32, 22, 2, 1
    function automatic logic take_bit();
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        return lfsr_q[0];
    endfunction

    function automatic logic [DATA_W-1:0] rand_word();
        logic [DATA_W-1:0] w;
        for (int i = 0; i < DATA_W; i++) begin
            w[i] = take_bit();
        end
        return w;
    endfunction

    function automatic void ref_write(logic [MEM_AW-1:0] a, logic [DATA_W-1:0] d,
                                      logic [STRB_W-1:0] s);
        for (int b = 0; b < STRB_W; b++) begin
            if (s[b]) ref_mem[a][b*8 +: 8] = d[b*8 +: 8];
        end
    endfunction

    task automatic report_mismatch(string name, logic [DATA_W-1:0] want, logic [DATA_W-1:0] got);
        $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, want, got);
        errors++;
    endtask

    task automatic report_failure(string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Expected beats are taken from the model before the request goes out
    task automatic send_read(int c, logic [ADDR_W-1:0] addr, int n);
        logic [MEM_AW-1:0] wa;
        wa = addr[WORD_LSB +: MEM_AW];
        for (int k = 0; k < n; k++) begin
            exp_data[c][exp_n[c] + k] = ref_mem[MEM_AW'(wa + k)];
            exp_last[c][exp_n[c] + k] = (k == n - 1);
        end
        exp_n[c] += n;
        @(negedge clk);
        rd_req[c].addr = addr;
        rd_req[c].len = LEN_W'(n - 1);
        rd_req_valid[c] = 1'b1;
        while (!rd_req_ready[c]) @(negedge clk);
        @(negedge clk);
        rd_req_valid[c] = 1'b0;
        while (got_n[c] != exp_n[c]) @(negedge clk);
    endtask

    task automatic send_write(logic [ADDR_W-1:0] addr, int n, logic partial);
        logic [MEM_AW-1:0] wa;
        wa = addr[WORD_LSB +: MEM_AW];
        @(negedge clk);
        wr_req.addr = addr;
        wr_req.len = LEN_W'(n - 1);
        wr_req_valid = 1'b1;
        while (!wr_req_ready) @(negedge clk);
        @(negedge clk);
        wr_req_valid = 1'b0;
        for (int k = 0; k < n; k++) begin
            wr_beat.data = rand_word();
            wr_beat.strb = '1;
            if (partial) begin
                for (int b = 0; b < STRB_W; b++) wr_beat.strb[b] = take_bit();
                // Byte 0 kept out so every word is a partial write
                wr_beat.strb[0] = 1'b0;
            end
            wr_beat.last = (k == n - 1);
            ref_write(MEM_AW'(wa + k), wr_beat.data, wr_beat.strb);
            wr_beat_valid = 1'b1;
            while (!wr_beat_ready) @(negedge clk);
            @(negedge clk);
            wr_beat_valid = 1'b0;
        end
        wr_resp_ready = 1'b1;
        while (!wr_resp_valid) @(negedge clk);
        @(negedge clk);
        wr_resp_ready = 1'b0;
    endtask

    always @(negedge clk) begin
        for (int c = 0; c < NUM_RD; c++) begin
            rd_beat_ready[c] = rand_ready ? take_bit() : 1'b1;
        end
    end

    // Accepted read beats and the open write response
    always @(posedge clk) begin
        if (!rst_n) begin
            resp_pending <= 1'b0;
        end else begin
            if (wr_beat_valid && wr_beat_ready && wr_beat.last) begin
                resp_pending <= 1'b1;
            end else if (wr_resp_valid && wr_resp_ready) begin
                resp_pending <= 1'b0;
            end
            for (int c = 0; c < NUM_RD; c++) begin
                if (rd_beat_valid[c] && rd_beat_ready[c]) got_n[c] <= got_n[c] + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (rd_beat_valid == '0 && !wr_resp_valid && !wr_beat_ready))
        else report_failure("a valid output was raised during reset");

    a_resp_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        wr_resp_valid |-> resp_pending)
        else report_failure("write response raised without a finished write burst");

    for (genvar c = 0; c < NUM_RD; c++) begin : g_rd_chk
        logic [DATA_W-1:0] want_data;
        logic              want_last;

        assign want_data = exp_data[c][got_n[c]];
        assign want_last = exp_last[c][got_n[c]];

        a_count: assert property (@(posedge clk) disable iff (!rst_n)
            (rd_beat_valid[c] && rd_beat_ready[c]) |-> got_n[c] < exp_n[c])
            else report_failure($sformatf("reader %0d returned more beats than requested", c));
        a_data: assert property (@(posedge clk) disable iff (!rst_n)
            (rd_beat_valid[c] && rd_beat_ready[c]) |-> rd_beat[c].data == want_data)
            else report_mismatch($sformatf("rd_beat[%0d].data", c), $sampled(want_data),
                                 $sampled(rd_beat[c].data));
        a_last: assert property (@(posedge clk) disable iff (!rst_n)
            (rd_beat_valid[c] && rd_beat_ready[c]) |-> rd_beat[c].last == want_last)
            else report_mismatch($sformatf("rd_beat[%0d].last", c), $sampled(want_last),
                                 $sampled(rd_beat[c].last));
        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            (rd_beat_valid[c] && !rd_beat_ready[c]) |=>
            (rd_beat_valid[c] && $stable(rd_beat[c])))
            else report_failure($sformatf("reader %0d changed a beat before it was taken", c));
    end

    initial begin
        @(negedge clk);
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        assert (rd_req_ready == {NUM_RD{1'b1}})
            else report_mismatch("rd_req_ready", {NUM_RD{1'b1}}, rd_req_ready);
        assert (wr_req_ready) else report_mismatch("wr_req_ready", 1'b1, wr_req_ready);
        assert (rd_beat_valid == '0) else report_mismatch("rd_beat_valid", '0, rd_beat_valid);
        assert (!wr_beat_ready) else report_mismatch("wr_beat_ready", 1'b0, wr_beat_ready);
        assert (!wr_resp_valid) else report_mismatch("wr_resp_valid", 1'b0, wr_resp_valid);
        end_test("idle_after_reset");

        send_write(32'h0000_0000, 8, 1'b0);
        send_read(0, 32'h0000_0000, 8);
        end_test("write_then_read");

        send_write(32'h0000_0020, 4, 1'b1);
        send_read(1, 32'h0000_0000, 8);
        end_test("partial_strobes");

        // Third region wraps past the top word and has low address bits set
        send_write(32'h0000_0400, 16, 1'b0);
        send_write(32'h0000_0800, 16, 1'b0);
        send_write(32'h0000_3fc7, 8, 1'b0);
        fork
            send_read(0, 32'h0000_0400, 5);
            send_read(1, 32'h0000_0800, 11);
            send_read(2, 32'h0000_3fc7, 8);
        join
        end_test("three_readers");

        rand_ready = 1'b1;
        fork
            send_read(0, 32'h0000_0800, 16);
            send_read(1, 32'h0000_3fc0, 8);
            send_read(2, 32'h0000_0400, 16);
        join
        rand_ready = 1'b0;
        end_test("random_backpressure");

        fork
            send_write(32'h0000_2000, 8, 1'b0);
            send_read(0, 32'h0000_0400, 16);
            send_read(1, 32'h0000_0800, 16);
        join
        send_read(2, 32'h0000_2000, 8);
        end_test("write_during_reads");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/dma_pkg.sv
hdl/word_ram.sv
hdl/mem_arbiter.sv
hdl/burst_reader.sv
hdl/burst_writer.sv
hdl/burst_ram_top.sv
verif/tb_clock.sv
verif/burst_ram_tb.sv
